// ==== compile.f ====
rtl/rp_sig_pkg.sv
rtl/rp_bus_pkg.sv
rtl/rp_axil_regs.sv
rtl/rp_adc_frontend.sv
rtl/rp_ramp_gen.sv
rtl/rp_prop_ctrl.sv
rtl/rp_dac_mixer.sv
rtl/rp_top.sv
dv/tb_rp_top.sv

// ==== Makefile ====
# Verilator build and run of the rp_top testbench

sim:
	verilator --binary --timing --top-module tb_rp_top -f compile.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== dv/tb_rp_top.sv ====
// testbench for rp_top: clock, reset, AXI4-Lite driver, cycle model, random test phases
`timescale 1ns/1ps

module tb_rp_top
  import rp_bus_pkg::*;
  import rp_sig_pkg::*;
();

  localparam int ACC_W    = 24;
  localparam int KP_SHIFT = 4;
  localparam int TIMEOUT  = 20;   // cycles per bus wait

  logic                   adc_clk, reset_i;
  logic [AXI_ADDR_W-1:0]  awaddr_i, araddr_i;
  logic                   awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic                   awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [AXI_DATA_W-1:0]  wdata_i, rdata_o;
  logic [AXI_STRB_W-1:0]  wstrb_i;
  logic [1:0]             bresp_o, rresp_o;
  adc_code_t [NUM_CH-1:0] adc_dat_i, dac_dat_o;

  integer seed;
  logic   extreme;        // adc codes at full scale only
  logic   started;        // model valid, checks on
  int     ctrl_clamps, mix_clamps;

  // cycle model state
  logic              m_live, m_bvalid, m_rvalid;
  logic              m_loop, m_ramp_en;
  logic [STEP_W-1:0] m_step [NUM_CH];
  int                m_setpoint, m_kp;
  int                m_smp [NUM_CH];
  logic [ACC_W-1:0]  m_acc [NUM_CH];
  int                m_ramp [NUM_CH];
  int                m_ctrl [NUM_CH];
  adc_code_t         m_dac [NUM_CH];

  rp_top #(.ACC_W(ACC_W), .KP_SHIFT(KP_SHIFT)) uut (.*);

  initial adc_clk = 1'b0;
  always #50 adc_clk = ~adc_clk;   // 100 ns period

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic string mismatch_text(input string sig, input logic [31:0] got,
                                          input logic [31:0] exp);
    return $sformatf("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, sig, got, exp);
  endfunction

  function automatic int clamp_sample(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  // neg-slope offset binary, code 0 is +full scale
  function automatic adc_code_t code_of(input int s);
    return adc_code_t'((8191 - s) & 16383);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // cycle model, updated on the same edge as the DUT
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin : cycle_model
    int               src, raw, sum;
    int               n_smp [NUM_CH];
    int               n_ramp [NUM_CH];
    int               n_ctrl [NUM_CH];
    adc_code_t        n_dac [NUM_CH];
    logic [ACC_W-1:0] n_acc [NUM_CH];
    logic             wr_acc, rd_rdy;
    wr_acc = awvalid_i && wvalid_i && !m_bvalid && m_live;
    rd_rdy = !m_rvalid && m_live;
    // ready outputs seen just before this edge takes effect
    if (started)
    begin
      assert (awready_o == wr_acc)
      else stop_with_error(mismatch_text("awready_o", 32'(awready_o), 32'(wr_acc)));
      assert (wready_o == wr_acc)
      else stop_with_error(mismatch_text("wready_o", 32'(wready_o), 32'(wr_acc)));
      assert (arready_o == rd_rdy)
      else stop_with_error(mismatch_text("arready_o", 32'(arready_o), 32'(rd_rdy)));
    end
    started = 1'b1;
    if (reset_i)
    begin
      {m_live, m_bvalid, m_rvalid, m_loop, m_ramp_en} = '0;
      m_setpoint = 0;
      m_kp       = 0;
      for (int i = 0; i < NUM_CH; i++)
      begin
        m_step[i] = '0;
        m_acc[i]  = '0;
        m_smp[i]  = 0;
        m_ramp[i] = 0;
        m_ctrl[i] = 0;
        m_dac[i]  = 14'h1FFF;   // zero sample
      end
    end
    else
    begin
      for (int i = 0; i < NUM_CH; i++)
      begin
        src       = m_loop ? int'(m_dac[i]) : int'(adc_dat_i[i]);
        n_smp[i]  = 8191 - src;
        n_acc[i]  = m_ramp_en ? m_acc[i] + ACC_W'(m_step[i]) : '0;
        n_ramp[i] = int'(n_acc[i] >> (ACC_W - SMP_W));
        if (n_ramp[i] > 8191)
          n_ramp[i] = n_ramp[i] - 16384;   // top bits read as signed
        raw = ((m_setpoint - m_smp[i]) * m_kp) >>> KP_SHIFT;
        if (raw != clamp_sample(raw))
          ctrl_clamps++;
        n_ctrl[i] = clamp_sample(raw);
        sum = m_ramp[i] + m_ctrl[i];
        if (sum != clamp_sample(sum))
          mix_clamps++;
        n_dac[i] = code_of(clamp_sample(sum));
      end
      // register mirror, written with the old values already used above
      if (wr_acc)
      begin
        m_bvalid = 1'b1;
        case (awaddr_i)
          REG_CTRL:
          begin
            m_loop    = wdata_i[0];
            m_ramp_en = wdata_i[1];
          end
          REG_STEP_A:   m_step[0]  = wdata_i[STEP_W-1:0];
          REG_STEP_B:   m_step[1]  = wdata_i[STEP_W-1:0];
          REG_SETPOINT: m_setpoint = int'($signed(wdata_i[SMP_W-1:0]));
          REG_KP:       m_kp       = int'(wdata_i[KP_W-1:0]);
          default:      ;   // id and unmapped stay untouched
        endcase
      end
      else if (bready_i)
        m_bvalid = 1'b0;
      if (arvalid_i && rd_rdy)
        m_rvalid = 1'b1;
      else if (rready_i)
        m_rvalid = 1'b0;
      m_live = 1'b1;
      for (int i = 0; i < NUM_CH; i++)
      begin
        m_smp[i]  = n_smp[i];
        m_acc[i]  = n_acc[i];
        m_ramp[i] = n_ramp[i];
        m_ctrl[i] = n_ctrl[i];
        m_dac[i]  = n_dac[i];
      end
    end
  end

  // outputs are registered, stable at the falling edge
  always @(negedge adc_clk)
  begin : output_checks
    if (started)
    begin
      for (int i = 0; i < NUM_CH; i++)
        assert (dac_dat_o[i] == m_dac[i])
        else stop_with_error(mismatch_text($sformatf("dac_dat_o[%0d]", i),
                                           32'(dac_dat_o[i]), 32'(m_dac[i])));
      assert (bvalid_o == m_bvalid)
      else stop_with_error(mismatch_text("bvalid_o", 32'(bvalid_o), 32'(m_bvalid)));
      assert (rvalid_o == m_rvalid)
      else stop_with_error(mismatch_text("rvalid_o", 32'(rvalid_o), 32'(m_rvalid)));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks, all called on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_adc();
    logic [31:0] r;
    for (int i = 0; i < NUM_CH; i++)
    begin
      r = $random(seed);
      if (extreme)
        adc_dat_i[i] = r[0] ? 14'h0000 : 14'h3FFF;   // +full or -full scale
      else
        adc_dat_i[i] = r[SMP_W-1:0];
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n)
    begin
      @(negedge adc_clk);
      drive_adc();
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int t;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = 4'hF;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    t = 0;
    do
    begin
      @(negedge adc_clk);
      t++;
      if (t > TIMEOUT)
        stop_with_error("timeout: no write response from the DUT");
    end while (!bvalid_o);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    assert (bresp_o == exp_resp)
    else stop_with_error(mismatch_text("bresp_o", 32'(bresp_o), 32'(exp_resp)));
    bready_i = 1'b1;
    t = 0;
    do
    begin
      @(negedge adc_clk);
      t++;
      if (t > TIMEOUT)
        stop_with_error("timeout: write response never cleared");
    end while (bvalid_o);
    bready_i = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr);
    int          t;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    t = 0;
    do
    begin
      @(negedge adc_clk);
      t++;
      if (t > TIMEOUT)
        stop_with_error("timeout: no read response from the DUT");
    end while (!rvalid_o);
    arvalid_i = 1'b0;
    exp_resp  = RESP_OKAY;
    case (addr)
      REG_CTRL:     exp_data = {30'd0, m_ramp_en, m_loop};
      REG_STEP_A:   exp_data = {16'd0, m_step[0]};
      REG_STEP_B:   exp_data = {16'd0, m_step[1]};
      REG_SETPOINT: exp_data = {18'd0, m_setpoint[13:0]};   // masked to width
      REG_KP:       exp_data = {24'd0, m_kp[7:0]};
      REG_ID:       exp_data = RP_ID_WORD;
      default:
      begin
        exp_data = '0;
        exp_resp = RESP_SLVERR;
      end
    endcase
    assert (rdata_o == exp_data)
    else stop_with_error(mismatch_text("rdata_o", rdata_o, exp_data));
    assert (rresp_o == exp_resp)
    else stop_with_error(mismatch_text("rresp_o", 32'(rresp_o), 32'(exp_resp)));
    rready_i = 1'b1;
    t = 0;
    do
    begin
      @(negedge adc_clk);
      t++;
      if (t > TIMEOUT)
        stop_with_error("timeout: read response never cleared");
    end while (rvalid_o);
    rready_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : main_sequence
    logic [7:0]  wr_addrs [5];
    logic [7:0]  ua;
    logic [31:0] r;
    int          idx;
    wr_addrs = '{REG_CTRL, REG_STEP_A, REG_STEP_B, REG_SETPOINT, REG_KP};
    seed     = 32'haea382ef;
    started  = 1'b0;
    extreme  = 1'b0;
    ctrl_clamps = 0;
    mix_clamps  = 0;
    reset_i  = 1'b1;
    {awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i} = '0;
    awaddr_i = '0;
    araddr_i = '0;
    wdata_i  = '0;
    wstrb_i  = '0;
    adc_dat_i = '0;
    repeat (8) @(negedge adc_clk);   // 8 reset cycles
    reset_i = 1'b0;
    run_cycles(4);
    for (int i = 0; i < NUM_CH; i++)
      assert (dac_dat_o[i] == 14'h1FFF)
      else stop_with_error(mismatch_text($sformatf("dac_dat_o[%0d]", i),
                                         32'(dac_dat_o[i]), 32'h1FFF));

    // register map, random values read back
    repeat (24)
    begin
      idx = $unsigned($random(seed)) % 5;
      write_reg(wr_addrs[idx], $random(seed), RESP_OKAY);
      read_reg(wr_addrs[idx]);
    end
    read_reg(REG_ID);
    r  = $random(seed);
    ua = {r[7:2], 2'b00};
    if (ua < 8'h18)
      ua = ua + 8'h18;   // past the last mapped word
    write_reg(REG_ID, $random(seed), RESP_SLVERR);
    write_reg(ua, $random(seed), RESP_SLVERR);
    read_reg(ua);
    for (int i = 0; i < 5; i++)
      read_reg(wr_addrs[i]);   // nothing changed by the errors

    // proportional path only
    write_reg(REG_CTRL, 32'h0, RESP_OKAY);
    repeat (10)
    begin
      write_reg(REG_SETPOINT, $random(seed), RESP_OKAY);
      write_reg(REG_KP, $random(seed), RESP_OKAY);
      run_cycles(30);
    end

    // ramp only, then off again
    write_reg(REG_KP, 32'h0, RESP_OKAY);
    write_reg(REG_STEP_A, $random(seed), RESP_OKAY);
    write_reg(REG_STEP_B, $random(seed), RESP_OKAY);
    write_reg(REG_CTRL, 32'h2, RESP_OKAY);
    run_cycles(600);
    write_reg(REG_STEP_A, $random(seed), RESP_OKAY);   // step change on the fly
    run_cycles(100);
    write_reg(REG_CTRL, 32'h0, RESP_OKAY);
    run_cycles(5);
    for (int i = 0; i < NUM_CH; i++)
      assert (dac_dat_o[i] == 14'h1FFF)
      else stop_with_error(mismatch_text($sformatf("dac_dat_o[%0d]", i),
                                         32'(dac_dat_o[i]), 32'h1FFF));

    // both clamps, full gain and full-scale inputs
    extreme = 1'b1;
    ctrl_clamps = 0;   // count this phase only
    mix_clamps  = 0;
    write_reg(REG_KP, 32'hFF, RESP_OKAY);
    write_reg(REG_STEP_A, 32'hFFFF, RESP_OKAY);
    write_reg(REG_CTRL, 32'h2, RESP_OKAY);
    repeat (4)
    begin
      r = $random(seed);
      write_reg(REG_SETPOINT, r[0] ? 32'h1FFF : 32'h2000, RESP_OKAY);
      run_cycles(150);
    end
    if (ctrl_clamps == 0 || mix_clamps == 0)
      stop_with_error("controller or mixer saturation was never reached");

    // closed digital loop, adc codes keep changing
    extreme = 1'b0;
    repeat (4)
    begin
      write_reg(REG_KP, $random(seed), RESP_OKAY);
      write_reg(REG_SETPOINT, $random(seed), RESP_OKAY);
      write_reg(REG_STEP_B, $random(seed), RESP_OKAY);
      r = $random(seed);
      write_reg(REG_CTRL, {30'd0, r[1], 1'b1}, RESP_OKAY);
      run_cycles(200);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== rtl/rp_top.sv ====
// top level: register slave, ADC front end, ramp, controller and DAC mixer
`timescale 1ns/1ps

module rp_top
  import rp_bus_pkg::*;
  import rp_sig_pkg::*;
#(
  parameter int ACC_W    = 24,   // ramp accumulator width
  parameter int KP_SHIFT = 4     // controller scaling shift
)
(
  input  logic                   adc_clk,
  input  logic                   reset_i,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0]  awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [AXI_DATA_W-1:0]  wdata_i,
  input  logic [AXI_STRB_W-1:0]  wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic [1:0]             bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [AXI_ADDR_W-1:0]  araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [AXI_DATA_W-1:0]  rdata_o,
  output logic [1:0]             rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  // converters
  input  adc_code_t [NUM_CH-1:0] adc_dat_i,   // one word per channel
  output adc_code_t [NUM_CH-1:0] dac_dat_o
);

  ////////////////////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////////////////////

  logic                          digital_loop;
  logic                          ramp_en;
  logic [NUM_CH-1:0][STEP_W-1:0] step;
  sample_t                       setpoint;
  logic [KP_W-1:0]               kp;

  rp_axil_regs u_regs (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .awaddr_i       (awaddr_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .wdata_i        (wdata_i),
    .wstrb_i        (wstrb_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .bresp_o        (bresp_o),
    .bvalid_o       (bvalid_o),
    .bready_i       (bready_i),
    .araddr_i       (araddr_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .rdata_o        (rdata_o),
    .rresp_o        (rresp_o),
    .rvalid_o       (rvalid_o),
    .rready_i       (rready_i),
    .digital_loop_o (digital_loop),
    .ramp_en_o      (ramp_en),
    .step_o         (step),
    .setpoint_o     (setpoint),
    .kp_o           (kp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // analog path, three register stages ADC to DAC
  ////////////////////////////////////////////////////////////////////////////

  sample_t [NUM_CH-1:0] smp;    // front end out
  sample_t [NUM_CH-1:0] ramp;   // generator out
  sample_t [NUM_CH-1:0] ctrl;   // controller out

  rp_adc_frontend u_frontend (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .digital_loop_i (digital_loop),
    .adc_dat_i      (adc_dat_i),
    .dac_dat_i      (dac_dat_o),     // loop back path
    .smp_o          (smp)
  );

  rp_ramp_gen #(
    .ACC_W (ACC_W)
  ) u_ramp (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .ramp_en_i (ramp_en),
    .step_i    (step),
    .ramp_o    (ramp)
  );

  rp_prop_ctrl #(
    .KP_SHIFT (KP_SHIFT)
  ) u_ctrl (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .smp_i      (smp),
    .setpoint_i (setpoint),
    .kp_i       (kp),
    .ctrl_o     (ctrl)
  );

  rp_dac_mixer u_mixer (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .ramp_i    (ramp),
    .ctrl_i    (ctrl),
    .dac_dat_o (dac_dat_o)
  );

endmodule

// ==== rtl/rp_dac_mixer.sv ====
// DAC mixer: ramp plus controller, saturation, conversion to neg-slope code
`timescale 1ns/1ps

module rp_dac_mixer
  import rp_sig_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  sample_t   [NUM_CH-1:0] ramp_i,     // generator output
  input  sample_t   [NUM_CH-1:0] ctrl_i,     // controller output
  output adc_code_t [NUM_CH-1:0] dac_dat_o   // registered DAC codes
);

  sum_t      [NUM_CH-1:0] sum;
  sample_t   [NUM_CH-1:0] sat;
  adc_code_t [NUM_CH-1:0] dac_q;

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      sum[i] = sum_t'(ramp_i[i]) + sum_t'(ctrl_i[i]);
      // guard and sign bits disagree on overflow
      if (sum[i][SMP_W] != sum[i][SMP_W-1])
        sat[i] = sum[i][SMP_W] ? SMP_MIN : SMP_MAX;
      else
        sat[i] = sum[i][SMP_W-1:0];
    end
  end

  // back to neg-slope offset binary, sign kept and the rest inverted
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_CH; i++)
        dac_q[i] <= ZERO_CODE;   // 0x1FFF, mid scale
    end
    else
    begin
      for (int i = 0; i < NUM_CH; i++)
        dac_q[i] <= {sat[i][SMP_W-1], ~sat[i][SMP_W-2:0]};
    end
  end

  assign dac_dat_o = dac_q;

endmodule

// ==== rtl/rp_prop_ctrl.sv ====
// proportional controller per channel: error, gain, shift, clamp, register
`timescale 1ns/1ps

module rp_prop_ctrl
  import rp_sig_pkg::*;
#(
  parameter int KP_SHIFT = 4   // right shift after the multiply
)
(
  input  logic                 adc_clk,
  input  logic                 reset_i,
  input  sample_t [NUM_CH-1:0] smp_i,       // measured samples
  input  sample_t              setpoint_i,  // common to both channels
  input  logic [KP_W-1:0]      kp_i,        // unsigned gain
  output sample_t [NUM_CH-1:0] ctrl_o
);

  // error has one guard bit, gain one sign bit in front
  localparam int PROD_W = SMP_W + 1 + KP_W + 1;

  logic signed [KP_W:0]         kp_s;
  sum_t        [NUM_CH-1:0]     err;
  logic signed [PROD_W-1:0]     prod   [NUM_CH];
  logic signed [PROD_W-1:0]     scaled [NUM_CH];
  sample_t     [NUM_CH-1:0]     sat;
  sample_t     [NUM_CH-1:0]     ctrl_q;

  assign kp_s = $signed({1'b0, kp_i});   // gain is never negative

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      err[i]    = sum_t'(setpoint_i) - sum_t'(smp_i[i]);  // cannot overflow 15 bits
      prod[i]   = err[i] * kp_s;
      scaled[i] = prod[i] >>> KP_SHIFT;                    // arithmetic, keeps sign
      // clamp to sample range
      if (scaled[i] > PROD_W'(SMP_MAX))
        sat[i] = SMP_MAX;
      else if (scaled[i] < PROD_W'(SMP_MIN))
        sat[i] = SMP_MIN;
      else
        sat[i] = scaled[i][SMP_W-1:0];
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ctrl_q <= '0;
    else
      ctrl_q <= sat;   // one cycle sample to output
  end

  assign ctrl_o = ctrl_q;

endmodule

// ==== rtl/rp_ramp_gen.sv ====
// ramp generator: one wrapping phase accumulator per channel
`timescale 1ns/1ps

module rp_ramp_gen
  import rp_sig_pkg::*;
#(
  parameter int ACC_W = 24   // accumulator width, at least STEP_W
)
(
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic                          ramp_en_i,  // low clears everything
  input  logic [NUM_CH-1:0][STEP_W-1:0] step_i,     // phase increment per cycle
  output sample_t [NUM_CH-1:0]          ramp_o
);

  logic [NUM_CH-1:0][ACC_W-1:0] acc_q;
  logic [NUM_CH-1:0][ACC_W-1:0] acc_nxt;
  sample_t [NUM_CH-1:0]         ramp_q;

  // step zero-extended, overflow wraps
  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
      acc_nxt[i] = acc_q[i] + ACC_W'(step_i[i]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // accumulator and output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i || !ramp_en_i)
    begin
      acc_q  <= '0;   // phase restarts at zero on enable
      ramp_q <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_CH; i++)
      begin
        acc_q[i]  <= acc_nxt[i];
        ramp_q[i] <= acc_nxt[i][ACC_W-1 -: SMP_W];  // top bits, read as signed
      end
    end
  end

  // sawtooth from 0 up to +max, jumps to -max, back up through 0
  assign ramp_o = ramp_q;

endmodule

// ==== rtl/rp_adc_frontend.sv ====
// ADC front end: loop source select, input register, neg-slope to two's complement
`timescale 1ns/1ps

module rp_adc_frontend
  import rp_sig_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  logic                     digital_loop_i,  // take DAC codes back in
  input  adc_code_t [NUM_CH-1:0]   adc_dat_i,       // raw ADC codes
  input  adc_code_t [NUM_CH-1:0]   dac_dat_i,       // fed-back DAC codes
  output sample_t   [NUM_CH-1:0]   smp_o            // registered samples
);

  adc_code_t [NUM_CH-1:0] src;     // selected code per channel
  sample_t   [NUM_CH-1:0] smp_q;

  ////////////////////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////////////////////

  // DAC and ADC share one code format, so the loop needs no conversion
  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
      src[i] = digital_loop_i ? dac_dat_i[i] : adc_dat_i[i];
  end

  // sign bit stays, magnitude bits flip (negative slope)
  // converted before the register so reset gives a zero sample
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      smp_q <= '0;
    else
    begin
      for (int i = 0; i < NUM_CH; i++)
        smp_q[i] <= {src[i][SMP_W-1], ~src[i][SMP_W-2:0]};
    end
  end

  assign smp_o = smp_q;

endmodule

// ==== rtl/rp_axil_regs.sv ====
// AXI4-Lite slave with control, ramp step, setpoint, gain and id registers
`timescale 1ns/1ps

module rp_axil_regs
  import rp_bus_pkg::*;
  import rp_sig_pkg::*;
(
  input  logic                             adc_clk,
  input  logic                             reset_i,
  // write address / data / response
  input  logic [AXI_ADDR_W-1:0]            awaddr_i,
  input  logic                             awvalid_i,
  output logic                             awready_o,
  input  logic [AXI_DATA_W-1:0]            wdata_i,
  input  logic [AXI_STRB_W-1:0]            wstrb_i,
  input  logic                             wvalid_i,
  output logic                             wready_o,
  output logic [1:0]                       bresp_o,
  output logic                             bvalid_o,
  input  logic                             bready_i,
  // read address / data
  input  logic [AXI_ADDR_W-1:0]            araddr_i,
  input  logic                             arvalid_i,
  output logic                             arready_o,
  output logic [AXI_DATA_W-1:0]            rdata_o,
  output logic [1:0]                       rresp_o,
  output logic                             rvalid_o,
  input  logic                             rready_i,
  // configuration out
  output logic                             digital_loop_o,
  output logic                             ramp_en_o,
  output logic [NUM_CH-1:0][STEP_W-1:0]    step_o,
  output sample_t                          setpoint_o,
  output logic [KP_W-1:0]                  kp_o
);

  logic                          live_q;      // set one cycle after reset
  logic                          loop_q;
  logic                          ramp_en_q;
  logic [NUM_CH-1:0][STEP_W-1:0] step_q;
  sample_t                       setpoint_q;
  logic [KP_W-1:0]               kp_q;
  logic                          bvalid_q, rvalid_q;
  logic [1:0]                    bresp_q, rresp_q;
  logic [AXI_DATA_W-1:0]         rdata_q;
  logic [AXI_ADDR_W-1:0]         aw_word, ar_word;  // byte offset forced to word
  logic                          wr_go, rd_go;
  logic                          wr_ok;
  logic [AXI_DATA_W:0]           wr_view, rd_view;  // {hit, current value}
  logic [AXI_DATA_W-1:0]         wr_data;           // value after byte merge

  // register view at a word address, msb flags a mapped offset
  function automatic logic [AXI_DATA_W:0] reg_view(input logic [AXI_ADDR_W-1:0] addr);
    logic [AXI_DATA_W:0] v;
    v = '0;
    v[AXI_DATA_W] = 1'b1;
    case (addr)
      REG_CTRL:     v[1:0] = {ramp_en_q, loop_q};
      REG_STEP_A:   v[STEP_W-1:0] = step_q[0];
      REG_STEP_B:   v[STEP_W-1:0] = step_q[1];
      REG_SETPOINT: v[SMP_W-1:0] = setpoint_q;   // masked, no sign extension
      REG_KP:       v[KP_W-1:0] = kp_q;
      REG_ID:       v[AXI_DATA_W-1:0] = RP_ID_WORD;
      default:      v = '0;                      // unmapped
    endcase
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshakes and decode
  ////////////////////////////////////////////////////////////////////////////

  assign aw_word = {awaddr_i[AXI_ADDR_W-1:2], 2'b00};
  assign ar_word = {araddr_i[AXI_ADDR_W-1:2], 2'b00};

  // address and data accepted together, only with no response pending
  assign wr_go     = awvalid_i & wvalid_i & ~bvalid_q & live_q;
  assign awready_o = wr_go;
  assign wready_o  = wr_go;

  assign arready_o = ~rvalid_q & live_q;
  assign rd_go     = arvalid_i & arready_o;

  always_comb
  begin
    wr_view = reg_view(aw_word);
    rd_view = reg_view(ar_word);
    wr_ok   = wr_view[AXI_DATA_W] & (aw_word != REG_ID);  // id is read only
    // old value in lanes without strobe
    for (int b = 0; b < AXI_STRB_W; b++)
      wr_data[b*8 +: 8] = wstrb_i[b] ? wdata_i[b*8 +: 8] : wr_view[b*8 +: 8];
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers and responses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      live_q     <= 1'b0;
      loop_q     <= 1'b0;
      ramp_en_q  <= 1'b0;
      step_q     <= '0;
      setpoint_q <= '0;
      kp_q       <= '0;
      bvalid_q   <= 1'b0;
      bresp_q    <= RESP_OKAY;
      rvalid_q   <= 1'b0;
      rresp_q    <= RESP_OKAY;
    end
    else
    begin
      live_q <= 1'b1;
      // write channel
      if (wr_go)
      begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (wr_ok)
        begin
          case (aw_word)
            REG_CTRL:
            begin
              loop_q    <= wr_data[0];
              ramp_en_q <= wr_data[1];
            end
            REG_STEP_A:   step_q[0]  <= wr_data[STEP_W-1:0];
            REG_STEP_B:   step_q[1]  <= wr_data[STEP_W-1:0];
            REG_SETPOINT: setpoint_q <= wr_data[SMP_W-1:0];
            REG_KP:       kp_q       <= wr_data[KP_W-1:0];
            default:      ;  // wr_ok excludes the rest
          endcase
        end
      end
      else if (bready_i)
        bvalid_q <= 1'b0;   // response taken
      // read channel
      if (rd_go)
      begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_view[AXI_DATA_W] ? RESP_OKAY : RESP_SLVERR;
      end
      else if (rready_i)
        rvalid_q <= 1'b0;
    end
  end

  // read data, zero for unmapped
  always_ff @(posedge adc_clk)
  begin
    if (rd_go)
      rdata_q <= rd_view[AXI_DATA_W-1:0];
  end

  assign bvalid_o       = bvalid_q;
  assign bresp_o        = bresp_q;
  assign rvalid_o       = rvalid_q;
  assign rresp_o        = rresp_q;
  assign rdata_o        = rdata_q;
  assign digital_loop_o = loop_q;
  assign ramp_en_o      = ramp_en_q;
  assign step_o         = step_q;
  assign setpoint_o     = setpoint_q;
  assign kp_o           = kp_q;

endmodule

// ==== rtl/rp_bus_pkg.sv ====
// configuration bus: AXI4-Lite widths, register map, response codes, id word
package rp_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int AXI_ADDR_W = 8;
  parameter int AXI_DATA_W = 32;
  parameter int AXI_STRB_W = AXI_DATA_W / 8;  // one strobe per byte lane

  ////////////////////////////////////////////////////////////////////////////
  // register byte offsets
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [AXI_ADDR_W-1:0] REG_CTRL     = 8'h00;  // [0] loop, [1] ramp
  parameter logic [AXI_ADDR_W-1:0] REG_STEP_A   = 8'h04;  // ramp step ch a
  parameter logic [AXI_ADDR_W-1:0] REG_STEP_B   = 8'h08;  // ramp step ch b
  parameter logic [AXI_ADDR_W-1:0] REG_SETPOINT = 8'h0C;  // signed, both channels
  parameter logic [AXI_ADDR_W-1:0] REG_KP       = 8'h10;  // unsigned gain
  parameter logic [AXI_ADDR_W-1:0] REG_ID       = 8'h14;  // read only

  // response codes
  parameter logic [1:0] RESP_OKAY   = 2'b00;
  parameter logic [1:0] RESP_SLVERR = 2'b10;

  // identification, "RP" plus a revision
  parameter logic [AXI_DATA_W-1:0] RP_ID_WORD = 32'h5250_0A01;

endpackage

// ==== rtl/rp_sig_pkg.sv ====
// analog path types: sample, converter code, sum, channel count, field widths
package rp_sig_pkg;

  parameter int NUM_CH = 2;    // analog channels, a and b
  parameter int SMP_W  = 14;   // converter resolution
  parameter int STEP_W = 16;   // ramp step field
  parameter int KP_W   = 8;    // unsigned proportional gain

  // two's complement sample, used everywhere inside the path
  typedef logic signed [SMP_W-1:0] sample_t;

  // raw negative-slope offset-binary code, same format on ADC and DAC pins
  typedef logic [SMP_W-1:0] adc_code_t;

  // one guard bit for sums and errors
  typedef logic signed [SMP_W:0] sum_t;

  // full-scale limits of a sample
  parameter sample_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};  // +8191
  parameter sample_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};  // -8192

  // DAC code for a zero sample, also the idle output
  parameter adc_code_t ZERO_CODE = {1'b0, {(SMP_W-1){1'b1}}};

endpackage
